// File: graph_color.f
design/color_pkg.sv
design/credit_fifo.sv
design/graph_ram.sv
design/color_rw.sv
design/color_worker.sv
design/color_engine.sv
verification/color_engine_asserts.sv
verification/color_checker.sv
verification/tb_color_engine.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_color_engine
FILELIST  := graph_color.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_color_engine.sv
`timescale 1ns/1ns

module tb_color_engine;

   localparam int NUM_GRAPHS       = 4;
   localparam int MAX_EDGES        = 12;
   localparam int TB_V             = 8;
   localparam int RESET_CYCLES     = 16;
   localparam int CYCLES_PER_GRAPH = 4000;

   logic                          clk;
   logic                          rstn;
   logic                          start;
   logic                          load_valid;
   logic [1:0]                    load_sel;
   logic [color_pkg::EADDR_W-1:0] load_addr;
   logic [color_pkg::LOAD_W-1:0]  load_data;
   logic                          color_ready;
   logic                          color_valid;
   logic [color_pkg::VID_W-1:0]   color_vertex;
   logic [color_pkg::COLOR_W-1:0] color_value;
   logic                          done;

   logic [color_pkg::COLOR_W-1:0] ref_color [color_pkg::MAX_V];
   logic [color_pkg::COLOR_W-1:0] table_row [color_pkg::MAX_V];
   int                            exp_count;
   int                            chk_results;
   int                            chk_errors;
   bit                            adj [TB_V][TB_V];

   // per graph: vertex count, edge count, enqueue limit, edge ends, hand-worked colours
   int graph_nv  [NUM_GRAPHS] = '{8, 6, 8, 5};
   int graph_ne  [NUM_GRAPHS] = '{8, 6, 12, 4};
   int graph_enq [NUM_GRAPHS] = '{8, 2, 3, 1};
   int edge_a [NUM_GRAPHS][MAX_EDGES] = '{
      '{0, 0, 1, 1, 2, 3, 4, 5, 0, 0, 0, 0},
      '{0, 1, 2, 3, 4, 5, 0, 0, 0, 0, 0, 0},
      '{0, 0, 0, 1, 1, 2, 3, 4, 5, 6, 2, 3},
      '{0, 1, 2, 2, 0, 0, 0, 0, 0, 0, 0, 0}};
   int edge_b [NUM_GRAPHS][MAX_EDGES] = '{
      '{1, 2, 2, 3, 3, 4, 5, 6, 0, 0, 0, 0},
      '{1, 2, 3, 4, 5, 0, 0, 0, 0, 0, 0, 0},
      '{1, 2, 3, 2, 4, 5, 6, 7, 6, 7, 7, 4},
      '{1, 2, 0, 3, 0, 0, 0, 0, 0, 0, 0, 0}};
   int table_color [NUM_GRAPHS][TB_V] = '{
      '{2, 0, 1, 2, 0, 1, 0, 0},
      '{0, 1, 0, 1, 0, 1, 0, 0},
      '{1, 2, 0, 0, 1, 2, 1, 2},
      '{1, 2, 0, 1, 0, 0, 0, 0}};

   color_engine dut (
      .clk(clk), .rstn(rstn), .start(start),
      .load_valid(load_valid), .load_sel(load_sel), .load_addr(load_addr),
      .load_data(load_data), .color_ready(color_ready),
      .color_valid(color_valid), .color_vertex(color_vertex),
      .color_value(color_value), .done(done)
   );

   color_checker chk (
      .clk(clk), .rstn(rstn), .color_valid(color_valid), .color_ready(color_ready),
      .color_vertex(color_vertex), .color_value(color_value), .done(done),
      .exp_count(exp_count), .ref_color(ref_color), .table_color(table_row),
      .results(chk_results), .errors(chk_errors)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // random stalls on the result port
   initial begin : ready_gen
      int hold;
      void'($urandom(32'h463b_88f5));
      hold = 0;
      color_ready = 1'b1;
      forever begin
         @(posedge clk);
         #5;
         if (hold > 0) begin
            hold = hold - 1;
         end else if (($urandom % 4) == 0) begin
            hold = int'($urandom % 6) + 1;
         end
         color_ready = (hold == 0);
      end
   end

   task automatic print_counts();
      $display("results checked: %0d, errors: %0d", chk_results, chk_errors);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #5;
      rstn       = 1'b0;
      start      = 1'b0;
      load_valid = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #5;
      rstn = 1'b1;
   endtask

   task automatic load_word(input logic [1:0] sel, input int addr,
                            input logic [color_pkg::LOAD_W-1:0] data);
      @(posedge clk);
      #5;
      load_valid = 1'b1;
      load_sel   = sel;
      load_addr  = color_pkg::EADDR_W'(addr);
      load_data  = data;
   endtask

   task automatic build_adjacency(input int g);
      for (int i = 0; i < TB_V; i++) begin
         for (int j = 0; j < TB_V; j++) begin
            adj[i][j] = 1'b0;
         end
      end
      for (int e = 0; e < graph_ne[g]; e++) begin
         adj[edge_a[g][e]][edge_b[g][e]] = 1'b1;
         adj[edge_b[g][e]][edge_a[g][e]] = 1'b1;
      end
   endtask

   // neighbour lists packed back to back, records point at their list
   task automatic load_graph(input int g);
      color_pkg::color_data_t rec;
      int offset;
      int deg;
      offset = 0;
      for (int v = 0; v < graph_nv[g]; v++) begin
         deg = 0;
         for (int u = 0; u < TB_V; u++) begin
            if (adj[v][u]) begin
               load_word(color_pkg::LOAD_EDGE, offset + deg, color_pkg::LOAD_W'(u));
               deg++;
            end
         end
         rec                 = '0;
         rec.eo_begin        = 16'(offset);
         rec.degree          = 16'(deg);
         rec.degrees_pending = 16'(deg);
         load_word(color_pkg::LOAD_VERTEX, v, rec);
         offset += deg;
      end
      load_word(color_pkg::LOAD_CFG, int'(color_pkg::CFG_NUM_V),
                color_pkg::LOAD_W'(graph_nv[g]));
      load_word(color_pkg::LOAD_CFG, int'(color_pkg::CFG_ENQ_LIMIT),
                color_pkg::LOAD_W'(graph_enq[g]));
      @(posedge clk);
      #5;
      load_valid = 1'b0;
   endtask

   // largest degree first, lowest id wins a tie
   task automatic compute_reference(input int g);
      int deg [TB_V];
      int col [TB_V];
      bit taken [TB_V];
      bit used [TB_V + 1];
      int best;
      int c;
      for (int v = 0; v < TB_V; v++) begin
         deg[v]   = 0;
         col[v]   = 0;
         taken[v] = 1'b0;
         for (int u = 0; u < TB_V; u++) begin
            deg[v] += int'(adj[v][u]);
         end
      end
      for (int step = 0; step < graph_nv[g]; step++) begin
         best = -1;
         for (int v = 0; v < graph_nv[g]; v++) begin
            if (!taken[v] && (best < 0 || deg[v] > deg[best])) begin
               best = v;
            end
         end
         for (int k = 0; k <= TB_V; k++) begin
            used[k] = 1'b0;
         end
         for (int u = 0; u < graph_nv[g]; u++) begin
            if (adj[best][u] && taken[u]) begin
               used[col[u]] = 1'b1;
            end
         end
         c = 0;
         while (used[c]) begin
            c++;
         end
         col[best]   = c;
         taken[best] = 1'b1;
      end
      for (int v = 0; v < TB_V; v++) begin
         ref_color[v] = color_pkg::COLOR_W'(col[v]);
      end
   endtask

   initial begin
      rstn       = 1'b0;
      start      = 1'b0;
      load_valid = 1'b0;
      load_sel   = '0;
      load_addr  = '0;
      load_data  = '0;
      exp_count  = 0;
      for (int v = 0; v < color_pkg::MAX_V; v++) begin
         ref_color[v] = '0;
         table_row[v] = '0;
      end
      for (int g = 0; g < NUM_GRAPHS; g++) begin
         build_adjacency(g);
         compute_reference(g);
         for (int v = 0; v < TB_V; v++) begin
            table_row[v] = color_pkg::COLOR_W'(table_color[g][v]);
         end
         exp_count = graph_nv[g];
         apply_reset();
         load_graph(g);
         @(posedge clk);
         #5;
         start = 1'b1;
         @(posedge clk);
         #5;
         start = 1'b0;
         while (!done) begin
            @(posedge clk);
            #5;
         end
         repeat (2) @(posedge clk);
      end
      print_counts();
      if (chk_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin
      repeat (NUM_GRAPHS * CYCLES_PER_GRAPH) @(posedge clk);
      $display("watchdog expired: the graphs were not all coloured in %0d cycles",
               NUM_GRAPHS * CYCLES_PER_GRAPH);
      print_counts();
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: verification/color_checker.sv
`timescale 1ns/1ns

module color_checker (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          color_valid,
   input  logic                          color_ready,
   input  logic [color_pkg::VID_W-1:0]   color_vertex,
   input  logic [color_pkg::COLOR_W-1:0] color_value,
   input  logic                          done,
   input  int                            exp_count,
   input  logic [color_pkg::COLOR_W-1:0] ref_color [color_pkg::MAX_V],
   input  logic [color_pkg::COLOR_W-1:0] table_color [color_pkg::MAX_V],
   output int                            results,
   output int                            errors
);

   logic seen [color_pkg::MAX_V];
   logic done_q;
   int   got;
   int   v;
   int   n_results = 0;
   int   n_errors = 0;

   assign results = n_results;
   assign errors  = n_errors;

   // per-graph state clears with the DUT reset, counts do not
   always @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < color_pkg::MAX_V; i++) begin
            seen[i] = 1'b0;
         end
         got    = 0;
         done_q = 1'b0;
      end else begin
         if (color_valid && color_ready) begin
            v = int'(color_vertex);
            n_results++;
            got++;
            if (v >= exp_count) begin
               $display("at %0t a result arrived for vertex %0d, outside the graph", $time, v);
               n_errors++;
            end else if (seen[v]) begin
               $display("at %0t vertex %0d was reported a second time", $time, v);
               n_errors++;
            end else begin
               seen[v] = 1'b1;
               if (color_value !== ref_color[v]) begin
                  $display("CHECK FAILED at %0t: color_value of vertex %0d is %0d, expected %0d",
                           $time, v, color_value, ref_color[v]);
                  n_errors++;
               end
               if (color_value !== table_color[v]) begin
                  $display("CHECK FAILED at %0t: color_value of vertex %0d is %0d, table says %0d",
                           $time, v, color_value, table_color[v]);
                  n_errors++;
               end
            end
         end
         // every vertex must be reported before done
         if (done && !done_q && got != exp_count) begin
            $display("at %0t done rose after %0d of %0d results", $time, got, exp_count);
            n_errors++;
         end
         done_q = done;
      end
   end

endmodule

// File: verification/color_engine_asserts.sv
`timescale 1ns/1ns

module color_engine_asserts (
   input logic                          clk,
   input logic                          rstn,
   input logic                          task_push,
   input logic                          task_credit,
   input logic                          res_push,
   input logic                          res_credit,
   input logic                          color_valid,
   input logic                          color_ready,
   input logic [color_pkg::VID_W-1:0]   color_vertex,
   input logic [color_pkg::COLOR_W-1:0] color_value,
   input logic                          done
);

   int task_credits;
   int res_credits;

   // shadow credit counters
   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_credits <= color_pkg::QUEUE_DEPTH;
         res_credits  <= color_pkg::RESULT_DEPTH;
      end else begin
         task_credits <= task_credits - int'(task_push) + int'(task_credit);
         res_credits  <= res_credits - int'(res_push) + int'(res_credit);
      end
   end

   task_push_has_credit: assert property (@(posedge clk) disable iff (!rstn)
      task_push |-> task_credits > 0)
      else $error("task queue push with no credit left");

   result_push_has_credit: assert property (@(posedge clk) disable iff (!rstn)
      res_push |-> res_credits > 0)
      else $error("result queue push with no credit left");

   result_held_while_stalled: assert property (@(posedge clk) disable iff (!rstn)
      (color_valid && !color_ready) |=>
      (color_valid && $stable(color_vertex) && $stable(color_value)))
      else $error("result port changed while color_ready was low");

   done_is_sticky: assert property (@(posedge clk) disable iff (!rstn)
      done |=> done)
      else $error("done fell without a reset");

endmodule

bind color_engine color_engine_asserts u_asserts (
   .clk          (clk),
   .rstn         (rstn),
   .task_push    (task_push),
   .task_credit  (task_credit),
   .res_push     (res_push),
   .res_credit   (res_credit),
   .color_valid  (color_valid),
   .color_ready  (color_ready),
   .color_vertex (color_vertex),
   .color_value  (color_value),
   .done         (done)
);

// File: design/color_engine.sv
`timescale 1ns/1ns

module color_engine (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          start,
   input  logic                          load_valid,
   input  logic [1:0]                    load_sel,
   input  logic [color_pkg::EADDR_W-1:0] load_addr,
   input  logic [color_pkg::LOAD_W-1:0]  load_data,
   input  logic                          color_ready,
   output logic                          color_valid,
   output logic [color_pkg::VID_W-1:0]   color_vertex,
   output logic [color_pkg::COLOR_W-1:0] color_value,
   output logic                          done
);

   color_pkg::color_task_t          task_head;
   color_pkg::color_task_t          task_q;
   color_pkg::color_task_t          push_task;
   color_pkg::color_task_t          rw_out_task;
   color_pkg::color_data_t          vram_rdata;
   color_pkg::color_data_t          vram_wdata;
   color_pkg::color_data_t          rw_wdata;
   color_pkg::color_result_t        res_push_data;
   color_pkg::color_result_t        res_head;
   logic [color_pkg::VADDR_W-1:0]   vram_waddr;
   logic [color_pkg::VADDR_W-1:0]   vram_raddr;
   logic [color_pkg::VID_W-1:0]     rw_waddr;
   logic [color_pkg::VID_W-1:0]     nbr_data;
   logic [color_pkg::EADDR_W-1:0]   nbr_addr;
   logic                            task_empty;
   logic                            task_credit;
   logic                            res_empty;
   logic                            res_credit;
   logic                            task_push;
   logic                            pop;
   logic                            task_valid_q;
   logic                            started;
   logic                            rw_wvalid;
   logic                            rw_out_valid;
   logic                            rw_busy;
   logic                            res_push;
   logic                            worker_idle;
   logic                            host_vwen;
   logic                            vram_wen;
   logic                            eram_wen;

   assign pop = !task_empty && !rw_busy && worker_idle;

   credit_fifo #(
      .payload_t (color_pkg::color_task_t),
      .DEPTH     (color_pkg::QUEUE_DEPTH)
   ) u_task_q (
      .clk(clk), .rstn(rstn), .push(task_push), .push_data(push_task), .pop(pop),
      .credit_return(task_credit), .pop_data(task_head), .empty(task_empty)
   );

   credit_fifo #(
      .payload_t (color_pkg::color_result_t),
      .DEPTH     (color_pkg::RESULT_DEPTH)
   ) u_result_q (
      .clk(clk), .rstn(rstn), .push(res_push), .push_data(res_push_data),
      .pop(color_valid && color_ready), .credit_return(res_credit),
      .pop_data(res_head), .empty(res_empty)
   );

   assign color_valid  = !res_empty;
   assign color_vertex = res_head.vertex;
   assign color_value  = res_head.color;

   // host owns the vertex RAM write port while loading
   assign host_vwen  = load_valid && (load_sel == color_pkg::LOAD_VERTEX);
   assign vram_wen   = host_vwen || rw_wvalid;
   assign vram_waddr = host_vwen ? load_addr[color_pkg::VADDR_W-1:0]
                                 : rw_waddr[color_pkg::VADDR_W-1:0];
   assign vram_wdata = host_vwen ? color_pkg::color_data_t'(load_data) : rw_wdata;
   // a stalled task re-reads its record
   assign vram_raddr = pop ? task_head.locale[color_pkg::VADDR_W-1:0]
                           : task_q.locale[color_pkg::VADDR_W-1:0];
   assign eram_wen   = load_valid && (load_sel == color_pkg::LOAD_EDGE);

   graph_ram #(
      .word_t (color_pkg::color_data_t),
      .DEPTH  (color_pkg::MAX_V)
   ) u_vertex_ram (
      .clk(clk), .wen(vram_wen), .waddr(vram_waddr), .wdata(vram_wdata),
      .raddr(vram_raddr), .rdata(vram_rdata)
   );

   graph_ram #(
      .word_t (logic [color_pkg::VID_W-1:0]),
      .DEPTH  (color_pkg::MAX_E)
   ) u_nbr_ram (
      .clk(clk), .wen(eram_wen), .waddr(load_addr),
      .wdata(load_data[color_pkg::VID_W-1:0]), .raddr(nbr_addr), .rdata(nbr_data)
   );

   color_rw u_rw (
      .clk(clk), .rstn(rstn), .task_valid(task_valid_q), .in_task(task_q),
      .in_data(vram_rdata), .result_credit_return(res_credit),
      .wvalid(rw_wvalid), .waddr(rw_waddr), .wdata(rw_wdata),
      .out_valid(rw_out_valid), .out_task(rw_out_task),
      .result_push(res_push), .result_data(res_push_data), .busy(rw_busy)
   );

   color_worker u_worker (
      .clk(clk), .rstn(rstn), .start(start),
      .load_valid(load_valid), .load_sel(load_sel), .load_addr(load_addr),
      .load_data(load_data), .in_valid(rw_out_valid), .in_task(rw_out_task),
      .nbr_data(nbr_data), .credit_return(task_credit), .nbr_addr(nbr_addr),
      .push(task_push), .push_task(push_task), .idle(worker_idle)
   );

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_valid_q <= 1'b0;
         started      <= 1'b0;
         done         <= 1'b0;
      end else begin
         // hold the task while rw waits on a result credit
         task_valid_q <= pop || (task_valid_q && rw_busy && !rw_out_valid);
         if (start) begin
            started <= 1'b1;
         end
         if (started && task_empty && res_empty && !task_valid_q && worker_idle) begin
            done <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         task_q <= task_head;
      end
   end

endmodule

// File: design/color_worker.sv
`timescale 1ns/1ns

module color_worker (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          start,
   input  logic                          load_valid,
   input  logic [1:0]                    load_sel,
   input  logic [color_pkg::EADDR_W-1:0] load_addr,
   input  logic [color_pkg::LOAD_W-1:0]  load_data,
   input  logic                          in_valid,
   input  color_pkg::color_task_t        in_task,
   input  logic [color_pkg::VID_W-1:0]   nbr_data,
   input  logic                          credit_return,
   output logic [color_pkg::EADDR_W-1:0] nbr_addr,
   output logic                          push,
   output color_pkg::color_task_t        push_task,
   output logic                          idle
);

   localparam int CW = $clog2(color_pkg::QUEUE_DEPTH + 1);

   typedef enum logic [1:0] {S_IDLE, S_WALK, S_ENQ} state_e;

   state_e                        state;
   color_pkg::color_task_t        cur;
   logic                          enq_more;
   logic [15:0]                   idx;
   logic [15:0]                   goal;
   logic [CW-1:0]                 credits;
   logic [color_pkg::VID_W-1:0]   num_v;
   logic [color_pkg::VID_W-1:0]   enq_limit;
   logic [color_pkg::VID_W-1:0]   remaining;
   logic [color_pkg::VID_W-1:0]   chunk;
   logic                          more;
   logic                          has_credit;

   // chunk for an incoming enqueue task
   always_comb begin
      remaining = (in_task.enq_start < num_v) ? num_v - in_task.enq_start : '0;
      more      = (remaining > enq_limit);
      chunk     = more ? enq_limit : remaining;
   end

   assign has_credit = (credits != '0);
   assign idle       = (state == S_IDLE);

   always_comb begin
      push      = 1'b0;
      push_task = '0;
      case (state)
         S_IDLE: begin
            push            = start && has_credit;
            push_task.ttype = color_pkg::TASK_ENQ;
         end
         S_WALK: begin
            push             = (idx != goal) && has_credit;
            push_task.ttype  = (cur.ttype == color_pkg::TASK_SEND_DEGREE) ?
                               color_pkg::TASK_RECEIVE_DEGREE : color_pkg::TASK_RECEIVE_COLOR;
            push_task.locale = nbr_data;
            push_task.sender = cur.locale;
            push_task.degree = cur.degree;
            push_task.color  = cur.color;
         end
         default: begin
            push             = (idx != goal) && has_credit;
            push_task.locale = cur.enq_start + idx[color_pkg::VID_W-1:0];
            // last child of a chunk re-enqueues the rest
            if (enq_more && (idx == goal - 16'd1)) begin
               push_task.ttype     = color_pkg::TASK_ENQ;
               push_task.enq_start = push_task.locale;
            end else begin
               push_task.ttype = color_pkg::TASK_SEND_DEGREE;
            end
         end
      endcase
   end

   // lookahead so the next neighbour is ready a cycle after a push
   assign nbr_addr = (state == S_IDLE) ? in_task.enq_start :
                     cur.enq_start + idx[color_pkg::EADDR_W-1:0] + color_pkg::EADDR_W'(push);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state     <= S_IDLE;
         idx       <= '0;
         goal      <= '0;
         credits   <= CW'(color_pkg::QUEUE_DEPTH);
         num_v     <= '0;
         enq_limit <= '0;
      end else begin
         credits <= credits - CW'(push) + CW'(credit_return);
         if (load_valid && load_sel == color_pkg::LOAD_CFG) begin
            if (load_addr == color_pkg::CFG_NUM_V) begin
               num_v <= load_data[color_pkg::VID_W-1:0];
            end else if (load_addr == color_pkg::CFG_ENQ_LIMIT) begin
               enq_limit <= load_data[color_pkg::VID_W-1:0];
            end
         end
         case (state)
            S_IDLE: begin
               if (in_valid) begin
                  idx <= '0;
                  if (in_task.ttype == color_pkg::TASK_ENQ) begin
                     state <= S_ENQ;
                     goal  <= 16'(chunk) + 16'(more);
                  end else begin
                     state <= S_WALK;
                     goal  <= in_task.degree;
                  end
               end
            end
            default: begin
               if (idx == goal) begin
                  state <= S_IDLE;
               end else if (push) begin
                  idx <= idx + 16'd1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (idle && in_valid) begin
         cur      <= in_task;
         enq_more <= more;
      end
   end

endmodule

// File: design/color_rw.sv
`timescale 1ns/1ns

module color_rw (
   input  logic                        clk,
   input  logic                        rstn,
   input  logic                        task_valid,
   input  color_pkg::color_task_t      in_task,
   input  color_pkg::color_data_t      in_data,
   input  logic                        result_credit_return,
   output logic                        wvalid,
   output logic [color_pkg::VID_W-1:0] waddr,
   output color_pkg::color_data_t      wdata,
   output logic                        out_valid,
   output color_pkg::color_task_t      out_task,
   output logic                        result_push,
   output color_pkg::color_result_t    result_data,
   output logic                        busy
);

   localparam int CW = $clog2(color_pkg::RESULT_DEPTH + 1);

   color_pkg::color_data_t            rec;
   color_pkg::color_data_t            nxt;
   color_pkg::color_data_t            fwd_data;
   logic [color_pkg::VID_W-1:0]       fwd_addr;
   logic                              fwd_valid;
   logic [color_pkg::COLOR_W-1:0]     new_color;
   logic [CW-1:0]                     credits;
   logic                              prio;
   logic                              upd;
   logic                              hand;
   logic                              finish;
   logic                              stall;
   logic                              go;

   always_comb begin
      // back-to-back task on the same vertex sees the last write
      rec = (fwd_valid && fwd_addr == in_task.locale) ? fwd_data : in_data;
      prio = (in_task.degree > rec.degree) ||
             ((in_task.degree == rec.degree) && (in_task.sender < in_task.locale));
      nxt    = rec;
      upd    = 1'b0;
      hand   = 1'b0;
      finish = 1'b0;
      case (in_task.ttype)
         color_pkg::TASK_ENQ: begin
            hand = 1'b1;
         end
         color_pkg::TASK_SEND_DEGREE: begin
            if (rec.degree == '0) begin
               upd    = 1'b1;
               finish = 1'b1;
            end else begin
               hand = 1'b1;
            end
         end
         color_pkg::TASK_RECEIVE_DEGREE: begin
            upd = 1'b1;
            nxt.degrees_pending = rec.degrees_pending - 16'd1;
            if (prio) begin
               nxt.colors_pending = rec.colors_pending + 8'd1;
            end
            finish = (nxt.degrees_pending == '0) && (nxt.colors_pending == '0);
         end
         default: begin
            // colours from lower-priority neighbours are ignored
            if (prio) begin
               upd = 1'b1;
               nxt.colors_pending = rec.colors_pending - 8'd1;
               if (in_task.color < color_pkg::COLOR_W'(color_pkg::NUM_COLORS)) begin
                  nxt.bitmap[in_task.color[color_pkg::COLOR_W-2:0]] = 1'b1;
               end
               finish = (nxt.degrees_pending == '0) && (nxt.colors_pending == '0);
            end
         end
      endcase
      // lowest clear bit, 32 when full
      new_color = color_pkg::COLOR_W'(color_pkg::NUM_COLORS);
      for (int i = color_pkg::NUM_COLORS - 1; i >= 0; i--) begin
         if (!nxt.bitmap[i]) begin
            new_color = color_pkg::COLOR_W'(i);
         end
      end
      if (finish) begin
         nxt.color = new_color;
         hand = (rec.degree != '0);
      end
   end

   always_comb begin
      out_task = in_task;
      if (in_task.ttype != color_pkg::TASK_ENQ) begin
         out_task.degree    = rec.degree;
         out_task.enq_start = rec.eo_begin[color_pkg::VID_W-1:0];
      end
      if (finish) begin
         out_task.ttype  = color_pkg::TASK_RECEIVE_COLOR;
         out_task.sender = in_task.locale;
         out_task.color  = new_color;
      end
   end

   assign stall       = task_valid && finish && (credits == '0);
   assign go          = task_valid && !stall;
   assign wvalid      = go && upd;
   assign waddr       = in_task.locale;
   assign wdata       = nxt;
   assign out_valid   = go && hand;
   assign result_push = go && finish;
   assign result_data = '{vertex: in_task.locale, color: new_color};
   assign busy        = task_valid && (stall || hand);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         credits   <= CW'(color_pkg::RESULT_DEPTH);
         fwd_valid <= 1'b0;
      end else begin
         credits   <= credits - CW'(result_push) + CW'(result_credit_return);
         fwd_valid <= wvalid;
      end
   end

   always_ff @(posedge clk) begin
      fwd_addr <= waddr;
      fwd_data <= wdata;
   end

endmodule

// File: design/graph_ram.sv
`timescale 1ns/1ns

module graph_ram #(
   parameter type word_t = logic [7:0],
   parameter int  DEPTH  = 32
) (
   input  logic                     clk,
   input  logic                     wen,
   input  logic [$clog2(DEPTH)-1:0] waddr,
   input  word_t                    wdata,
   input  logic [$clog2(DEPTH)-1:0] raddr,
   output word_t                    rdata
);

   word_t mem [DEPTH];

   // read returns the old word on a same-address write
   always_ff @(posedge clk) begin
      if (wen) begin
         mem[waddr] <= wdata;
      end
      rdata <= mem[raddr];
   end

endmodule

// File: design/credit_fifo.sv
`timescale 1ns/1ns

module credit_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 8
) (
   input  logic     clk,
   input  logic     rstn,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output logic     credit_return,
   output payload_t pop_data,
   output logic     empty
);

   localparam int AW = $clog2(DEPTH);

   payload_t       mem [DEPTH];
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [AW:0]    count;
   logic           do_pop;

   assign empty    = (count == '0);
   assign do_pop   = pop && !empty;
   // show-ahead head of queue
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         credit_return <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count         <= count + (AW + 1)'(push) - (AW + 1)'(do_pop);
         // one credit back per pop, a cycle later
         credit_return <= do_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

endmodule

// File: design/color_pkg.sv
package color_pkg;

   localparam int VID_W        = 8;
   localparam int MAX_V        = 32;
   localparam int MAX_E        = 256;
   localparam int COLOR_W      = 6;
   localparam int NUM_COLORS   = 32;
   localparam int QUEUE_DEPTH  = 64;
   localparam int RESULT_DEPTH = 8;

   localparam int VADDR_W = $clog2(MAX_V);
   localparam int EADDR_W = $clog2(MAX_E);

   // load_sel encodings
   localparam logic [1:0] LOAD_VERTEX = 2'd0;
   localparam logic [1:0] LOAD_EDGE   = 2'd1;
   localparam logic [1:0] LOAD_CFG    = 2'd2;

   // config addresses on the load port
   localparam logic [EADDR_W-1:0] CFG_NUM_V     = EADDR_W'(0);
   localparam logic [EADDR_W-1:0] CFG_ENQ_LIMIT = EADDR_W'(1);

   typedef enum logic [1:0] {
      TASK_ENQ,
      TASK_SEND_DEGREE,
      TASK_RECEIVE_DEGREE,
      TASK_RECEIVE_COLOR
   } ttype_e;

   // enq_start carries the list base on neighbour-walk hand-offs
   typedef struct packed {
      ttype_e             ttype;
      logic [VID_W-1:0]   locale;
      logic [VID_W-1:0]   sender;
      logic [15:0]        degree;
      logic [COLOR_W-1:0] color;
      logic [VID_W-1:0]   enq_start;
   } color_task_t;

   typedef struct packed {
      logic [15:0]           eo_begin;
      logic [15:0]           degrees_pending;
      logic [7:0]            colors_pending;
      logic [NUM_COLORS-1:0] bitmap;
      logic [15:0]           degree;
      logic [COLOR_W-1:0]    color;
   } color_data_t;

   typedef struct packed {
      logic [VID_W-1:0]   vertex;
      logic [COLOR_W-1:0] color;
   } color_result_t;

   // load_data carries a whole vertex record
   localparam int LOAD_W = $bits(color_data_t);

endpackage
